// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int LEN_LINE      = 5;
    localparam int LEN_INDEX     = 7;
    localparam int LEN_TAG       = 32 - LEN_LINE - LEN_INDEX;
    localparam int NR_WORDS      = 8;
    localparam int NR_WAYS       = 2;
    localparam int LEN_WORD_ADDR = LEN_INDEX + LEN_LINE - 2;

    // address fields and payloads
    typedef logic [LEN_TAG-1:0]    tag_t;
    typedef logic [LEN_INDEX-1:0]  index_t;
    typedef logic [LEN_LINE-3:0]   word_sel_t;
    typedef logic [31:0]           word_t;
    typedef logic [3:0]            strb_t;

    // miss sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL
    } state_t;

    // burst fields for one full line of 4-byte beats
    localparam logic [7:0] BURST_LEN  = 8'(NR_WORDS - 1);
    localparam logic [2:0] BURST_SIZE = 3'd2;

endpackage

// File: hdl/way_ram.sv
`timescale 1ns/1ps

module way_ram #(
    parameter type DATA_T = logic [31:0],
    parameter int  ADDR_W = 10
) (
    input  logic              clk,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_waddr,
    input  DATA_T             i_wdata,
    input  logic              i_re,
    input  logic [ADDR_W-1:0] i_raddr,
    output DATA_T             o_rdata
);
    DATA_T mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // same-cycle write wins over the stored word
    always_ff @(posedge clk) begin
        if (i_re) begin
            if (i_we && (i_waddr == i_raddr)) begin
                o_rdata <= i_wdata;
            end else begin
                o_rdata <= mem[i_raddr];
            end
        end
    end

endmodule

// File: hdl/dcache_decode.sv
`timescale 1ns/1ps

module dcache_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_req,
    input  logic                  i_wr,
    input  dcache_pkg::word_t     i_addr,
    input  dcache_pkg::word_t     i_wdata,
    input  dcache_pkg::strb_t     i_wstrb,
    input  logic                  i_busy,
    input  dcache_pkg::tag_t      i_tag_rd [dcache_pkg::NR_WAYS],
    input  logic                  i_meta_we,
    input  logic                  i_meta_way,
    input  logic                  i_meta_dirty,
    output dcache_pkg::index_t    o_rd_index,
    output dcache_pkg::word_sel_t o_rd_word,
    output logic                  o_lookup,
    output logic                  o_hit,
    output logic                  o_hit_way,
    output logic                  o_victim_way,
    output logic                  o_victim_dirty,
    output dcache_pkg::tag_t      o_victim_tag,
    output logic                  o_req_wr,
    output dcache_pkg::tag_t      o_req_tag,
    output dcache_pkg::index_t    o_req_index,
    output dcache_pkg::word_sel_t o_req_word,
    output dcache_pkg::word_t     o_req_wdata,
    output dcache_pkg::strb_t     o_req_wstrb,
    output logic                  o_store_hit_we
);
    import dcache_pkg::*;

    logic [NR_WAYS-1:0] valid_q  [2**LEN_INDEX];
    logic [NR_WAYS-1:0] dirty_q  [2**LEN_INDEX];
    logic               victim_q [2**LEN_INDEX];
    logic [NR_WAYS-1:0] hit_vec;
    logic               sel_way;
    logic               capture;

    // read side of the RAMs follows the incoming address
    assign o_rd_index = i_addr[LEN_LINE +: LEN_INDEX];
    assign o_rd_word  = i_addr[2 +: LEN_LINE-2];

    // a missing request stays put for the sequencer
    assign capture = i_req && !i_busy && !(o_lookup && !o_hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_lookup <= 1'b0;
        end else begin
            o_lookup <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_req_wr    <= i_wr;
            o_req_tag   <= i_addr[31 -: LEN_TAG];
            o_req_index <= o_rd_index;
            o_req_word  <= o_rd_word;
            o_req_wdata <= i_wdata;
            o_req_wstrb <= i_wstrb;
        end
    end

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            hit_vec[w] = valid_q[o_req_index][w] && (i_tag_rd[w] == o_req_tag);
        end
    end

    assign o_hit          = o_lookup && (|hit_vec);
    assign o_hit_way      = hit_vec[1];
    assign sel_way        = o_hit ? o_hit_way : victim_q[o_req_index];
    assign o_victim_way   = sel_way;
    assign o_victim_dirty = valid_q[o_req_index][sel_way] && dirty_q[o_req_index][sel_way];
    assign o_victim_tag   = i_tag_rd[sel_way];
    assign o_store_hit_we = o_hit && o_req_wr;

    // refill update from the sequencer, else hit bookkeeping
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '{default: '0};
            dirty_q  <= '{default: '0};
            victim_q <= '{default: 1'b0};
        end else if (i_meta_we) begin
            valid_q[o_req_index][i_meta_way] <= 1'b1;
            dirty_q[o_req_index][i_meta_way] <= i_meta_dirty;
            victim_q[o_req_index]            <= !i_meta_way;
        end else if (o_hit) begin
            if (o_req_wr) begin
                dirty_q[o_req_index][o_hit_way] <= 1'b1;
            end
            victim_q[o_req_index] <= !o_hit_way;
        end
    end

endmodule

// File: hdl/dcache_execute.sv
`timescale 1ns/1ps

module dcache_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_lookup,
    input  logic                     i_hit,
    input  logic                     i_victim_way,
    input  logic                     i_victim_dirty,
    input  dcache_pkg::tag_t         i_victim_tag,
    input  dcache_pkg::tag_t         i_req_tag,
    input  dcache_pkg::index_t       i_req_index,
    input  dcache_pkg::word_sel_t    i_req_word,
    input  logic                     i_req_wr,
    input  dcache_pkg::word_t        i_data_rd [dcache_pkg::NR_WAYS],
    input  logic                     i_arready,
    input  dcache_pkg::word_t        i_rdata,
    input  logic                     i_rlast,
    input  logic                     i_rvalid,
    input  logic                     i_awready,
    input  logic                     i_wready,
    input  logic                     i_bvalid,
    output logic                     o_busy,
    output logic                     o_done_miss,
    output dcache_pkg::word_sel_t    o_wb_rd_word,
    output logic [dcache_pkg::NR_WAYS-1:0] o_fill_we,
    output dcache_pkg::word_sel_t    o_fill_word,
    output dcache_pkg::word_t        o_fill_data,
    output logic                     o_crit_beat,
    output logic                     o_meta_we,
    output logic                     o_meta_way,
    output logic                     o_meta_dirty,
    output dcache_pkg::word_t        o_araddr,
    output logic [7:0]               o_arlen,
    output logic [2:0]               o_arsize,
    output logic                     o_arvalid,
    output logic                     o_rready,
    output dcache_pkg::word_t        o_awaddr,
    output logic [7:0]               o_awlen,
    output logic [2:0]               o_awsize,
    output logic                     o_awvalid,
    output dcache_pkg::word_t        o_wdata,
    output dcache_pkg::strb_t        o_wstrb,
    output logic                     o_wlast,
    output logic                     o_wvalid,
    output logic                     o_bready
);
    import dcache_pkg::*;

    state_t    state;
    word_sel_t cnt;
    logic      way_q;
    logic      start;
    logic      w_fire;
    logic      r_fire;

    assign start  = (state == ST_IDLE) && i_lookup && !i_hit;
    assign w_fire = o_wvalid && i_wready;
    assign r_fire = i_rvalid && o_rready;

    assign o_arlen  = BURST_LEN;
    assign o_arsize = BURST_SIZE;
    assign o_awlen  = BURST_LEN;
    assign o_awsize = BURST_SIZE;
    assign o_wstrb  = 4'hf;
    assign o_bready = 1'b1;

    // read one word ahead so the RAM output is the beat on the bus
    assign o_wb_rd_word = cnt + word_sel_t'(w_fire);
    assign o_wdata      = i_data_rd[way_q];

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            o_fill_we[w] = r_fire && (way_q == 1'(w));
        end
    end

    assign o_fill_word  = cnt;
    assign o_fill_data  = i_rdata;
    assign o_crit_beat  = r_fire && (cnt == i_req_word);
    assign o_meta_we    = r_fire && i_rlast;
    assign o_meta_way   = way_q;
    assign o_meta_dirty = i_req_wr;

    // victim and burst addresses are fixed for the whole miss
    always_ff @(posedge clk) begin
        if (start) begin
            way_q    <= i_victim_way;
            o_araddr <= {i_req_tag, i_req_index, {LEN_LINE{1'b0}}};
            o_awaddr <= {i_victim_tag, i_req_index, {LEN_LINE{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            o_busy      <= 1'b0;
            o_done_miss <= 1'b0;
            o_arvalid   <= 1'b0;
            o_rready    <= 1'b0;
            o_awvalid   <= 1'b0;
            o_wvalid    <= 1'b0;
            o_wlast     <= 1'b0;
        end else begin
            o_done_miss <= 1'b0;
            if (o_done_miss) begin
                o_busy <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        o_busy <= 1'b1;
                        cnt    <= '0;
                        if (i_victim_dirty) begin
                            o_awvalid <= 1'b1;
                            state     <= ST_WRITEBACK;
                        end else begin
                            o_arvalid <= 1'b1;
                            state     <= ST_REFILL;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (o_awvalid && i_awready) begin
                        o_awvalid <= 1'b0;
                        o_wvalid  <= 1'b1;
                    end
                    if (w_fire) begin
                        cnt     <= cnt + 1'b1;
                        o_wlast <= (cnt == word_sel_t'(NR_WORDS - 2));
                        if (o_wlast) begin
                            o_wvalid <= 1'b0;
                            o_wlast  <= 1'b0;
                        end
                    end
                    // fetch the new line once the write response arrives
                    if (i_bvalid && o_bready) begin
                        cnt       <= '0;
                        o_arvalid <= 1'b1;
                        state     <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        cnt <= cnt + 1'b1;
                        if (i_rlast) begin
                            o_rready    <= 1'b0;
                            o_done_miss <= 1'b1;
                            state       <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/dcache_result.sv
`timescale 1ns/1ps

module dcache_result (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_lookup,
    input  logic              i_hit_way,
    input  dcache_pkg::word_t i_data_rd [dcache_pkg::NR_WAYS],
    input  dcache_pkg::word_t i_rdata,
    input  logic              i_crit_beat,
    input  dcache_pkg::word_t i_req_wdata,
    input  dcache_pkg::strb_t i_req_wstrb,
    output dcache_pkg::word_t o_merge_data,
    output dcache_pkg::word_t o_rdata
);
    import dcache_pkg::*;

    word_t base;
    word_t crit_q;

    // hit writes merge into the stored word, refills into the beat
    assign base = i_lookup ? i_data_rd[i_hit_way] : i_rdata;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            o_merge_data[8*b +: 8] = i_req_wstrb[b] ? i_req_wdata[8*b +: 8] : base[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crit_q <= '0;
        end else if (i_crit_beat) begin
            crit_q <= i_rdata;
        end
    end

    assign o_rdata = i_lookup ? i_data_rd[i_hit_way] : crit_q;

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  logic              i_wr,
    input  dcache_pkg::word_t i_addr,
    input  dcache_pkg::word_t i_wdata,
    input  dcache_pkg::strb_t i_wstrb,
    output logic              o_busy,
    output logic              o_done,
    output dcache_pkg::word_t o_rdata,
    output dcache_pkg::word_t o_araddr,
    output logic [7:0]        o_arlen,
    output logic [2:0]        o_arsize,
    output logic              o_arvalid,
    input  logic              i_arready,
    input  dcache_pkg::word_t i_rdata,
    input  logic              i_rlast,
    input  logic              i_rvalid,
    output logic              o_rready,
    output dcache_pkg::word_t o_awaddr,
    output logic [7:0]        o_awlen,
    output logic [2:0]        o_awsize,
    output logic              o_awvalid,
    input  logic              i_awready,
    output dcache_pkg::word_t o_wdata,
    output dcache_pkg::strb_t o_wstrb,
    output logic              o_wlast,
    output logic              o_wvalid,
    input  logic              i_wready,
    input  logic              i_bvalid,
    output logic              o_bready
);
    import dcache_pkg::*;

    index_t    rd_index;
    word_sel_t rd_word;
    logic      lookup;
    logic      hit;
    logic      hit_way;
    logic      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    logic      req_wr;
    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;
    word_t     req_wdata;
    strb_t     req_wstrb;
    logic      store_hit_we;
    logic      meta_we;
    logic      meta_way;
    logic      meta_dirty;
    logic      done_miss;
    word_sel_t wb_rd_word;
    logic [NR_WAYS-1:0] fill_we;
    word_sel_t fill_word;
    word_t     fill_data;
    logic      crit_beat;
    word_t     merge_data;
    tag_t      tag_rd [NR_WAYS];
    word_t     data_rd [NR_WAYS];
    logic [LEN_WORD_ADDR-1:0] data_raddr;
    logic [LEN_WORD_ADDR-1:0] data_waddr;
    word_t     data_wdata;

    assign o_done = hit || done_miss;

    // sequencer owns the data RAM ports during a miss
    assign data_raddr = o_busy ? {req_index, wb_rd_word} : {rd_index, rd_word};
    assign data_waddr = o_busy ? {req_index, fill_word} : {req_index, req_word};
    assign data_wdata = (store_hit_we || (crit_beat && req_wr)) ? merge_data : fill_data;

    dcache_decode decode_i (
        .clk            (clk),
        .rst            (rst),
        .i_req          (i_req),
        .i_wr           (i_wr),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_wstrb        (i_wstrb),
        .i_busy         (o_busy),
        .i_tag_rd       (tag_rd),
        .i_meta_we      (meta_we),
        .i_meta_way     (meta_way),
        .i_meta_dirty   (meta_dirty),
        .o_rd_index     (rd_index),
        .o_rd_word      (rd_word),
        .o_lookup       (lookup),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_req_wr       (req_wr),
        .o_req_tag      (req_tag),
        .o_req_index    (req_index),
        .o_req_word     (req_word),
        .o_req_wdata    (req_wdata),
        .o_req_wstrb    (req_wstrb),
        .o_store_hit_we (store_hit_we)
    );

    dcache_execute execute_i (
        .clk            (clk),
        .rst            (rst),
        .i_lookup       (lookup),
        .i_hit          (hit),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_req_tag      (req_tag),
        .i_req_index    (req_index),
        .i_req_word     (req_word),
        .i_req_wr       (req_wr),
        .i_data_rd      (data_rd),
        .i_arready      (i_arready),
        .i_rdata        (i_rdata),
        .i_rlast        (i_rlast),
        .i_rvalid       (i_rvalid),
        .i_awready      (i_awready),
        .i_wready       (i_wready),
        .i_bvalid       (i_bvalid),
        .o_busy         (o_busy),
        .o_done_miss    (done_miss),
        .o_wb_rd_word   (wb_rd_word),
        .o_fill_we      (fill_we),
        .o_fill_word    (fill_word),
        .o_fill_data    (fill_data),
        .o_crit_beat    (crit_beat),
        .o_meta_we      (meta_we),
        .o_meta_way     (meta_way),
        .o_meta_dirty   (meta_dirty),
        .o_araddr       (o_araddr),
        .o_arlen        (o_arlen),
        .o_arsize       (o_arsize),
        .o_arvalid      (o_arvalid),
        .o_rready       (o_rready),
        .o_awaddr       (o_awaddr),
        .o_awlen        (o_awlen),
        .o_awsize       (o_awsize),
        .o_awvalid      (o_awvalid),
        .o_wdata        (o_wdata),
        .o_wstrb        (o_wstrb),
        .o_wlast        (o_wlast),
        .o_wvalid       (o_wvalid),
        .o_bready       (o_bready)
    );

    dcache_result result_i (
        .clk          (clk),
        .rst          (rst),
        .i_lookup     (lookup),
        .i_hit_way    (hit_way),
        .i_data_rd    (data_rd),
        .i_rdata      (i_rdata),
        .i_crit_beat  (crit_beat),
        .i_req_wdata  (req_wdata),
        .i_req_wstrb  (req_wstrb),
        .o_merge_data (merge_data),
        .o_rdata      (o_rdata)
    );

    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        way_ram #(
            .DATA_T (tag_t),
            .ADDR_W (LEN_INDEX)
        ) tag_ram_i (
            .clk     (clk),
            .i_we    (fill_we[w]),
            .i_waddr (req_index),
            .i_wdata (req_tag),
            .i_re    (i_req),
            .i_raddr (rd_index),
            .o_rdata (tag_rd[w])
        );

        way_ram #(
            .DATA_T (word_t),
            .ADDR_W (LEN_WORD_ADDR)
        ) data_ram_i (
            .clk     (clk),
            .i_we    (fill_we[w] || (store_hit_we && (hit_way == 1'(w)))),
            .i_waddr (data_waddr),
            .i_wdata (data_wdata),
            .i_re    (i_req || o_busy),
            .i_raddr (data_raddr),
            .o_rdata (data_rd[w])
        );
    end

endmodule

// File: verif/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_lookup,
    input  logic              i_hit,
    input  logic              i_busy,
    input  logic              i_done_miss,
    input  logic              i_arvalid,
    input  logic              i_arready,
    input  dcache_pkg::word_t i_araddr,
    input  logic              i_awvalid,
    input  logic              i_awready,
    input  dcache_pkg::word_t i_awaddr,
    input  logic              i_wvalid,
    input  logic              i_wready,
    input  dcache_pkg::word_t i_wdata,
    input  logic              i_wlast
);
    logic [2:0]  beat_cnt;
    int unsigned fail_count = 0;

    // write beats since the last accepted write address
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (i_awvalid && i_awready) begin
            beat_cnt <= '0;
        end else if (i_wvalid && i_wready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
        $error("read address valid dropped or changed before acceptance");
        fail_count = fail_count + 1;
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
        $error("write address valid dropped or changed before acceptance");
        fail_count = fail_count + 1;
    end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
    else begin
        $error("write data valid dropped or changed before acceptance");
        fail_count = fail_count + 1;
    end

    wlast_pos: assert property (@(posedge clk) disable iff (rst)
        i_wvalid |-> (i_wlast == (beat_cnt == 3'd7)))
    else begin
        $error("write last flag not on the eighth beat");
        fail_count = fail_count + 1;
    end

    no_dual_addr: assert property (@(posedge clk) disable iff (rst)
        !(i_arvalid && i_awvalid))
    else begin
        $error("read and write address valid high together");
        fail_count = fail_count + 1;
    end

    done_cause: assert property (@(posedge clk) disable iff (rst)
        (i_done_miss || i_hit) && !$past(i_busy) |-> i_lookup && !i_done_miss)
    else begin
        $error("done pulse without a request or a miss in progress");
        fail_count = fail_count + 1;
    end

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    typedef enum {LOAD, STORE, MEMCHK} op_e;

    typedef struct {
        string name;
        op_e   op;
        word_t addr;
        word_t data;
        strb_t strb;
        bit    hit;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_req;
    logic        cpu_wr;
    word_t       cpu_addr;
    word_t       cpu_wdata;
    strb_t       cpu_wstrb;
    logic        cpu_busy;
    logic        cpu_done;
    word_t       cpu_rdata;
    word_t       araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready = 1'b0;
    word_t       rdata   = '0;
    logic        rlast   = 1'b0;
    logic        rvalid  = 1'b0;
    logic        rready;
    word_t       awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready = 1'b0;
    word_t       wdata;
    strb_t       wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready  = 1'b0;
    logic        bvalid  = 1'b0;
    logic        bready;

    word_t       mem_model [4096];
    word_t       ref_img   [4096];
    entry_t      table_q [$];
    logic [15:0] lfsr    = 16'd94;
    logic [11:0] rd_ptr  = '0;
    int          rd_left = 0;
    logic [11:0] wr_ptr  = '0;
    logic        b_pend  = 1'b0;
    string       cur_name = "reset";
    int          value_errs   = 0;
    int          timeout_errs = 0;
    int          timeout_cycles = 2000;

    dcache_top dut_i (
        .clk (clk), .rst (rst), .i_req (cpu_req), .i_wr (cpu_wr), .i_addr (cpu_addr),
        .i_wdata (cpu_wdata), .i_wstrb (cpu_wstrb), .o_busy (cpu_busy), .o_done (cpu_done),
        .o_rdata (cpu_rdata), .o_araddr (araddr), .o_arlen (arlen), .o_arsize (arsize),
        .o_arvalid (arvalid), .i_arready (arready), .i_rdata (rdata), .i_rlast (rlast),
        .i_rvalid (rvalid), .o_rready (rready), .o_awaddr (awaddr), .o_awlen (awlen),
        .o_awsize (awsize), .o_awvalid (awvalid), .i_awready (awready), .o_wdata (wdata),
        .o_wstrb (wstrb), .o_wlast (wlast), .o_wvalid (wvalid), .i_wready (wready),
        .i_bvalid (bvalid), .o_bready (bready)
    );

    bind dcache_execute dcache_asserts asserts_i (
        .clk (clk), .rst (rst), .i_lookup (i_lookup), .i_hit (i_hit), .i_busy (o_busy),
        .i_done_miss (o_done_miss), .i_arvalid (o_arvalid), .i_arready (i_arready),
        .i_araddr (o_araddr), .i_awvalid (o_awvalid), .i_awready (i_awready),
        .i_awaddr (o_awaddr), .i_wvalid (o_wvalid), .i_wready (i_wready),
        .i_wdata (o_wdata), .i_wlast (o_wlast)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t apply_strobes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // burst memory slave deciding each beat for the coming rising edge
    always @(negedge clk) begin : mem_slave
        logic ar_fire;
        logic r_fire;
        logic aw_fire;
        logic w_fire;
        lfsr    = lfsr_next(lfsr);
        arready = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        awready = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        wready  = lfsr[0];
        rvalid  = (rd_left > 0);
        rlast   = (rd_left == 1);
        rdata   = mem_model[rd_ptr];
        bvalid  = b_pend;
        b_pend  = 1'b0;
        ar_fire = arvalid && arready;
        r_fire  = rvalid && rready;
        aw_fire = awvalid && awready;
        w_fire  = wvalid && wready;
        check_word({cur_name, " bready"}, 32'd1, 32'(bready));
        if (r_fire) begin
            rd_ptr  = rd_ptr + 1'b1;
            rd_left = rd_left - 1;
        end
        // eight beats of four bytes per line
        if (ar_fire) begin
            check_word({cur_name, " arlen"}, 32'd7, 32'(arlen));
            check_word({cur_name, " arsize"}, 32'd2, 32'(arsize));
            rd_ptr  = araddr[13:2];
            rd_left = 8;
        end
        if (aw_fire) begin
            check_word({cur_name, " awlen"}, 32'd7, 32'(awlen));
            check_word({cur_name, " awsize"}, 32'd2, 32'(awsize));
            wr_ptr = awaddr[13:2];
        end
        if (w_fire) begin
            check_word({cur_name, " wstrb"}, 32'hf, 32'(wstrb));
            mem_model[wr_ptr] = wdata;
            wr_ptr = wr_ptr + 1'b1;
            b_pend = wlast;
        end
    end

    task automatic add_entry(input string name, input op_e op, input word_t addr,
                             input word_t data, input strb_t strb, input bit hit);
        table_q.push_back('{name, op, addr, data, strb, hit});
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic wait_idle(output bit ok);
        int cycles;
        cycles = 0;
        while (cpu_busy && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        ok = !cpu_busy;
        if (!ok) begin
            $display("timed out waiting for the cache to become idle");
            timeout_errs++;
        end
    endtask

    task automatic wait_done(input string name, output int lat, output bit ok);
        @(negedge clk);
        cpu_req = 1'b0;
        lat = 1;
        while (!cpu_done && lat < timeout_cycles) begin
            @(negedge clk);
            lat++;
        end
        ok = cpu_done;
        if (!ok) begin
            $display("%s timed out waiting for the done pulse", name);
            timeout_errs++;
        end
    endtask

    initial begin : stimulus
        entry_t      e;
        int          lat;
        int          idx;
        bit          ok;
        int unsigned assert_fails;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        for (int i = 0; i < 4096; i++) begin
            mem_model[i] = {4'h5, 12'(i) ^ 12'hc3a, 2'b00, 12'(i), 2'b00};
            ref_img[i]   = mem_model[i];
        end
        // set 3 with tags 0, 1, 2 and set 10 with tags 0 to 3
        add_entry("load_cold",        LOAD,   32'h0000_0064, 32'h0,         4'h0, 1'b0);
        add_entry("load_hit_w1",      LOAD,   32'h0000_0064, 32'h0,         4'h0, 1'b1);
        add_entry("load_hit_w7",      LOAD,   32'h0000_007c, 32'h0,         4'h0, 1'b1);
        add_entry("store_hit_part",   STORE,  32'h0000_0068, 32'hdead_beef, 4'h5, 1'b1);
        add_entry("load_merged",      LOAD,   32'h0000_0068, 32'h0,         4'h0, 1'b1);
        add_entry("store_hit_b2b",    STORE,  32'h0000_0070, 32'h1122_3344, 4'h8, 1'b1);
        add_entry("load_b2b",         LOAD,   32'h0000_0070, 32'h0,         4'h0, 1'b1);
        add_entry("load_b2b_again",   LOAD,   32'h0000_0070, 32'h0,         4'h0, 1'b1);
        add_entry("store_miss",       STORE,  32'h0000_0148, 32'hcafe_f00d, 4'h3, 1'b0);
        add_entry("load_store_miss",  LOAD,   32'h0000_0148, 32'h0,         4'h0, 1'b1);
        add_entry("load_line_w0",     LOAD,   32'h0000_0140, 32'h0,         4'h0, 1'b1);
        add_entry("load_tag1",        LOAD,   32'h0000_1060, 32'h0,         4'h0, 1'b0);
        add_entry("load_tag2_evict",  LOAD,   32'h0000_2064, 32'h0,         4'h0, 1'b0);
        add_entry("mem_wb_w2",        MEMCHK, 32'h0000_0068, 32'h0,         4'h0, 1'b0);
        add_entry("mem_wb_w4",        MEMCHK, 32'h0000_0070, 32'h0,         4'h0, 1'b0);
        add_entry("load_tag1_hit",    LOAD,   32'h0000_1060, 32'h0,         4'h0, 1'b1);
        add_entry("reload_tag0",      LOAD,   32'h0000_0068, 32'h0,         4'h0, 1'b0);
        add_entry("reload_tag0_w4",   LOAD,   32'h0000_0070, 32'h0,         4'h0, 1'b1);
        add_entry("store_tag1_set10", STORE,  32'h0000_1148, 32'h0bad_cafe, 4'hf, 1'b0);
        add_entry("load_tag2_set10",  LOAD,   32'h0000_2150, 32'h0,         4'h0, 1'b0);
        add_entry("mem_set10_tag0",   MEMCHK, 32'h0000_0148, 32'h0,         4'h0, 1'b0);
        add_entry("load_tag1_set10",  LOAD,   32'h0000_1148, 32'h0,         4'h0, 1'b1);
        add_entry("reload_set10",     LOAD,   32'h0000_0148, 32'h0,         4'h0, 1'b0);
        add_entry("load_tag3_set10",  LOAD,   32'h0000_3144, 32'h0,         4'h0, 1'b0);
        add_entry("mem_set10_tag1",   MEMCHK, 32'h0000_1148, 32'h0,         4'h0, 1'b0);

        repeat (8) @(negedge clk);
        rst = 1'b0;

        foreach (table_q[n]) begin
            e   = table_q[n];
            idx = int'(e.addr[13:2]);
            if (e.op == MEMCHK) begin
                check_word(e.name, ref_img[idx], mem_model[idx]);
                continue;
            end
            wait_idle(ok);
            if (!ok) begin
                break;
            end
            cur_name  = e.name;
            cpu_req   = 1'b1;
            cpu_wr    = (e.op == STORE);
            cpu_addr  = e.addr;
            cpu_wdata = e.data;
            cpu_wstrb = e.strb;
            wait_done(e.name, lat, ok);
            if (!ok) begin
                break;
            end
            if (e.hit && lat != 1) begin
                $display("[FAIL] %s latency: expected 1, actual %0d", e.name, lat);
                value_errs++;
            end
            if (!e.hit && lat == 1) begin
                $display("%s was expected to miss, but finished as a hit", e.name);
                value_errs++;
            end
            // a miss holds busy through its done pulse
            if (cpu_busy !== !e.hit) begin
                $display("[FAIL] %s busy at done: expected %0b, actual %0b",
                         e.name, !e.hit, cpu_busy);
                value_errs++;
            end
            if (e.op == LOAD) begin
                check_word(e.name, ref_img[idx], cpu_rdata);
            end else begin
                ref_img[idx] = apply_strobes(ref_img[idx], e.data, e.strb);
            end
        end

        assert_fails = dut_i.execute_i.asserts_i.fail_count;
        $display("errors: value %0d, timeout %0d, assertion %0d",
                 value_errs, timeout_errs, assert_fails);
        if (value_errs == 0 && timeout_errs == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dcache.f
hdl/dcache_pkg.sv
hdl/way_ram.sv
hdl/dcache_decode.sv
hdl/dcache_execute.sv
hdl/dcache_result.sv
hdl/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/way_ram.sv
      - hdl/dcache_decode.sv
      - hdl/dcache_execute.sv
      - hdl/dcache_result.sv
      - hdl/dcache_top.sv
  - target: test
    files:
      - verif/dcache_asserts.sv
      - verif/dcache_tb.sv
